//--- build.f
+incdir+tests
logic/anchor_pkg.sv
logic/cabs_math_pkg.sv
logic/delay_line.sv
logic/anchor_ingress.sv
logic/cabs_core.sv
logic/cabs_collect.sv
logic/anchor_cabs_top.sv
tests/anchor_cabs_tb.sv

//--- Makefile
# Verilator build and run for the anchor magnitude subsystem

VERILATOR ?= verilator
TOP       ?= anchor_cabs_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

FAIL_MSG  := Some tests failed
SIM       := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "overridable: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

test: $(SIM)
	@./$(SIM) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/anchor_cabs_cases.svh
//////////////////////////////////////////////////////////////////////
// Stimulus table for the anchor magnitude testbench.
// Included inside the testbench module after word_t and the geometry
// localparams. Expected magnitudes come from the model below.
//////////////////////////////////////////////////////////////////////

`ifndef ANCHOR_CABS_CASES_SVH
`define ANCHOR_CABS_CASES_SVH

localparam int NUM_CASES = 8;

// each word is {ch3, ch2, ch1, ch0}, each channel is {im, re}
word_t case_word [NUM_CASES] = '{
  {32'h0000_0000, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
  {32'h8000_8000, 32'h8000_0000, 32'h0000_8000, 32'h8000_7FFF},
  {32'h1234_1234, 32'hEDCC_1234, 32'h1234_EDCC, 32'hEDCC_EDCC},
  {32'hFFFF_0001, 32'h0001_FFFF, 32'h7FFF_8001, 32'h8001_7FFF},
  {32'h7FFF_7FFF, 32'h0000_7FFF, 32'h7FFF_0000, 32'h0007_0003},
  {32'hC000_4000, 32'h3000_D000, 32'h0100_FF00, 32'hFFF8_0005},
  {32'h0003_FFFD, 32'h0010_0001, 32'hA5A5_5A5A, 32'h5A5A_A5A5},
  {32'h0001_0000, 32'h0000_0001, 32'hFFFF_FFFF, 32'h000F_0008}
};

word_t case_abs [NUM_CASES];

// max + min/4 + min/8 per channel, zero-extended into its lane
function automatic word_t model_abs(input word_t w);
  word_t                        r;
  logic signed [WORD_WIDTH-1:0] re;
  logic signed [WORD_WIDTH-1:0] im;
  int                           a;
  int                           b;
  int                           larger;
  int                           smaller;
  r = '0;
  for (int n = 0; n < NUM_CHANNELS; n++) begin
    re = w[n*CHANNEL_WIDTH +: WORD_WIDTH];
    im = w[n*CHANNEL_WIDTH+WORD_WIDTH +: WORD_WIDTH];
    a = (re < 0) ? -int'(re) : int'(re);
    b = (im < 0) ? -int'(im) : int'(im);
    larger = (a > b) ? a : b;
    smaller = (a > b) ? b : a;
    r[n*CHANNEL_WIDTH +: WORD_WIDTH] = WORD_WIDTH'(larger + (smaller >> 2) + (smaller >> 3));
  end
  return r;
endfunction

task automatic fill_expected();
  for (int i = 0; i < NUM_CASES; i++) begin
    case_abs[i] = model_abs(case_word[i]);
  end
endtask

`endif

//--- tests/anchor_cabs_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the anchor magnitude subsystem.
// Runs the case table once with free flow and once with random
// output stalls and input gaps, checking every output beat.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module anchor_cabs_tb import anchor_pkg::*, cabs_math_pkg::*;;

  localparam int NUM_CHANNELS  = NUM_CHANNELS_DEF;
  localparam int CHANNEL_WIDTH = CHANNEL_WIDTH_DEF;
  localparam int WORD_WIDTH    = word_width(CHANNEL_WIDTH);
  localparam int DATA_WIDTH    = CHANNEL_WIDTH * NUM_CHANNELS;

  typedef logic [DATA_WIDTH-1:0] word_t;
  typedef logic [WORD_WIDTH-1:0] mag_t;

  `include "anchor_cabs_cases.svh"

  localparam logic [31:0] SEED       = 32'h9af29c04;
  localparam word_t       FLUSH_WORD = '0;
  localparam int          TARGET     = 2 * NUM_CASES;
  // two passes over the table plus a few flush words
  localparam int TOTAL_WORDS     = TARGET + 4;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * (NUM_CHANNELS + CABS_DELAY + 8) + 100;

  logic  clk;
  logic  rst;
  logic  in_valid;
  logic  in_ready;
  word_t in_data;
  logic  out_valid;
  logic  out_ready;
  word_t out_data;
  word_t out_abs;

  word_t exp_data_q [$];
  word_t exp_abs_q [$];
  word_t want_data;
  word_t want_abs;
  word_t held_data;
  word_t held_abs;
  bit    stalled;
  bit    bp_on;
  int    rx_count;

  anchor_cabs_top #(
    .NUM_CHANNELS  (NUM_CHANNELS),
    .CHANNEL_WIDTH (CHANNEL_WIDTH)
  ) dut0 (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .out_abs   (out_abs)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_mag(input string name, input mag_t got, input mag_t exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    if (got != exp) begin
      abort_run($sformatf("[FAIL] t=%0t %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // driver
  //////////////////////////////////////////////////////////////////////

  // present one word until it is taken, called at 1 ns past an edge
  task automatic send_word(input word_t w, input word_t w_abs, input bit timed);
    int cycles;
    bit acc;
    cycles = 0;
    acc = 1'b0;
    in_valid = 1'b1;
    in_data = w;
    while (!acc) begin
      @(negedge clk);
      acc = in_ready;
      cycles++;
      @(posedge clk);
      #1;
    end
    exp_data_q.push_back(w);
    exp_abs_q.push_back(w_abs);
    if (timed) begin
      check_count("cycles per accepted word", cycles, NUM_CHANNELS);
    end
  endtask

  task automatic idle_cycles(input int n);
    in_valid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // random out_ready gaps once back-pressure is switched on
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (bp_on) begin
        out_ready = ($urandom % 3) != 0;
      end else begin
        out_ready = 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output monitor, sampled at the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (rst) begin
      stalled = 1'b0;
    end else begin
      // stalled beat must hold still
      if (stalled) begin
        check_bit("out_valid", out_valid, 1'b1);
        check_data("out_data", out_data, held_data);
        check_data("out_abs", out_abs, held_abs);
      end
      if (out_valid && out_ready) begin
        if (exp_data_q.size() == 0) begin
          abort_run("an output beat arrived with no input word outstanding");
        end else begin
          want_data = exp_data_q.pop_front();
          want_abs = exp_abs_q.pop_front();
          check_data("out_data", out_data, want_data);
          for (int n = 0; n < NUM_CHANNELS; n++) begin
            check_mag($sformatf("out_abs lane %0d", n),
                      out_abs[n*CHANNEL_WIDTH +: WORD_WIDTH],
                      want_abs[n*CHANNEL_WIDTH +: WORD_WIDTH]);
          end
          // whole word also covers the zero pad of each lane
          check_data("out_abs", out_abs, want_abs);
          rx_count++;
        end
      end
      stalled = out_valid && !out_ready;
      held_data = out_data;
      held_abs = out_abs;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    abort_run($sformatf("watchdog expired after %0d cycles, results still missing",
                        WATCHDOG_CYCLES));
  end

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    void'($urandom(SEED));
    rst = 1'b1;
    in_valid = 1'b0;
    in_data = '0;
    out_ready = 1'b1;
    bp_on = 1'b0;
    rx_count = 0;
    stalled = 1'b0;
    fill_expected();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // idle after reset
    repeat (2) begin
      @(negedge clk);
      check_bit("out_valid", out_valid, 1'b0);
      check_bit("in_ready", in_ready, 1'b0);
    end
    @(posedge clk);
    #1;

    // free flow, in_ready every NUM_CHANNELS cycles
    for (int i = 0; i < NUM_CASES; i++) begin
      send_word(case_word[i], case_abs[i], 1'b1);
    end

    // output stalls and input gaps
    bp_on = 1'b1;
    for (int i = 0; i < NUM_CASES; i++) begin
      idle_cycles($urandom % 3);
      send_word(case_word[i], case_abs[i], 1'b0);
    end

    // the pipeline only moves on input steps, so keep feeding
    while (rx_count < TARGET) begin
      send_word(FLUSH_WORD, model_abs(FLUSH_WORD), 1'b0);
    end
    in_valid = 1'b0;

    $display("All tests passed");
    $finish;
  end

endmodule

//--- logic/anchor_cabs_top.sv
//////////////////////////////////////////////////////////////////////
// Top level of the anchor magnitude subsystem.
// Takes one multi-channel word per input beat and returns the word
// with its per-channel magnitudes on one output beat.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module anchor_cabs_top import anchor_pkg::*, cabs_math_pkg::*; #(
  parameter int NUM_CHANNELS  = NUM_CHANNELS_DEF,
  parameter int CHANNEL_WIDTH = CHANNEL_WIDTH_DEF,

  localparam int WORD_WIDTH  = word_width(CHANNEL_WIDTH),
  localparam int DATA_WIDTH  = CHANNEL_WIDTH * NUM_CHANNELS,
  localparam int COUNT_WIDTH = count_width(NUM_CHANNELS)
) (
  input  logic                  clk,
  input  logic                  rst,

  input  logic                  in_valid,
  output logic                  in_ready,
  input  logic [DATA_WIDTH-1:0] in_data,

  output logic                  out_valid,
  input  logic                  out_ready,
  output logic [DATA_WIDTH-1:0] out_data,
  output logic [DATA_WIDTH-1:0] out_abs
);

  // channel tag carried alongside the magnitude
  typedef struct packed {
    logic [COUNT_WIDTH-1:0] chan;
    logic                   last;
  } tag_t;

  typedef logic [DATA_WIDTH-1:0] word_t;

  logic                         step;
  logic                         hold;
  logic signed [WORD_WIDTH-1:0] re;
  logic signed [WORD_WIDTH-1:0] im;
  logic [COUNT_WIDTH-1:0]       chan;
  logic                         last;
  logic [WORD_WIDTH-1:0]        mag;
  tag_t                         tag_in;
  tag_t                         tag_d;
  word_t                        word_d;

  assign tag_in.chan = chan;
  assign tag_in.last = last;

  anchor_ingress #(
    .NUM_CHANNELS  (NUM_CHANNELS),
    .CHANNEL_WIDTH (CHANNEL_WIDTH)
  ) u_ingress (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_data  (in_data),
    .hold     (hold),
    .in_ready (in_ready),
    .step     (step),
    .re       (re),
    .im       (im),
    .chan     (chan),
    .last     (last)
  );

  cabs_core #(
    .NUM_CHANNELS  (NUM_CHANNELS),
    .CHANNEL_WIDTH (CHANNEL_WIDTH)
  ) u_core (
    .clk  (clk),
    .rst  (rst),
    .step (step),
    .re   (re),
    .im   (im),
    .mag  (mag)
  );

  // tag lines up with mag, word lags one more step for the lane write
  delay_line #(
    .DEPTH     (CABS_DELAY),
    .payload_t (tag_t)
  ) u_tag_dly (
    .clk  (clk),
    .rst  (rst),
    .step (step),
    .din  (tag_in),
    .dout (tag_d)
  );

  delay_line #(
    .DEPTH     (CABS_DELAY + 1),
    .payload_t (word_t)
  ) u_word_dly (
    .clk  (clk),
    .rst  (rst),
    .step (step),
    .din  (in_data),
    .dout (word_d)
  );

  cabs_collect #(
    .NUM_CHANNELS  (NUM_CHANNELS),
    .CHANNEL_WIDTH (CHANNEL_WIDTH)
  ) u_collect (
    .clk       (clk),
    .rst       (rst),
    .step      (step),
    .mag       (mag),
    .chan_d    (tag_d.chan),
    .last_d    (tag_d.last),
    .word_d    (word_d),
    .out_ready (out_ready),
    .hold      (hold),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_abs   (out_abs)
  );

endmodule

//--- logic/cabs_collect.sv
//////////////////////////////////////////////////////////////////////
// Output side of the magnitude subsystem.
// Gathers per-channel magnitudes into lanes, flags a finished word
// and hands word plus magnitudes to the output register. Raises
// hold to freeze the pipeline while a result waits.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cabs_collect import anchor_pkg::*; #(
  parameter int NUM_CHANNELS  = NUM_CHANNELS_DEF,
  parameter int CHANNEL_WIDTH = CHANNEL_WIDTH_DEF,

  localparam int WORD_WIDTH  = word_width(CHANNEL_WIDTH),
  localparam int DATA_WIDTH  = CHANNEL_WIDTH * NUM_CHANNELS,
  localparam int COUNT_WIDTH = count_width(NUM_CHANNELS),
  localparam int PAD_WIDTH   = CHANNEL_WIDTH - WORD_WIDTH
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   step,
  input  logic [WORD_WIDTH-1:0]  mag,
  input  logic [COUNT_WIDTH-1:0] chan_d,
  input  logic                   last_d,
  input  logic [DATA_WIDTH-1:0]  word_d,
  input  logic                   out_ready,
  output logic                   hold,
  output logic                   out_valid,
  output logic [DATA_WIDTH-1:0]  out_data,
  output logic [DATA_WIDTH-1:0]  out_abs
);

  logic [WORD_WIDTH-1:0] lane_mem [NUM_CHANNELS];
  logic [DATA_WIDTH-1:0] abs_word;

  logic tag_fresh;
  logic last_rise;
  logic result_rdy;
  logic out_take;
  logic out_load;

  //////////////////////////////////////////////////////////////////////
  // magnitude lanes
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_CHANNELS; i++) begin
        lane_mem[i] <= '0;
      end
    end else if (step) begin
      lane_mem[chan_d] <= mag;
    end
  end

  // zero-extend each magnitude into its channel slot
  for (genvar n = 0; n < NUM_CHANNELS; n++) begin : g_pack
    assign abs_word[n*CHANNEL_WIDTH +: CHANNEL_WIDTH] = {{PAD_WIDTH{1'b0}}, lane_mem[n]};
  end

  //////////////////////////////////////////////////////////////////////
  // result flag and stall
  //////////////////////////////////////////////////////////////////////

  // a tag reaches the delay output on the cycle after a step,
  // so a fresh last tag marks the rising edge of last_d
  always_ff @(posedge clk) begin
    if (rst) begin
      tag_fresh <= 1'b0;
    end else begin
      tag_fresh <= step;
    end
  end

  assign last_rise = last_d & tag_fresh;
  assign out_take  = out_valid & out_ready;
  assign out_load  = out_take | ~out_valid;

  always_ff @(posedge clk) begin
    if (rst) begin
      result_rdy <= 1'b0;
    end else if (last_rise) begin
      result_rdy <= 1'b1;
    end else if (out_load) begin
      result_rdy <= 1'b0;
    end
  end

  // freeze while a finished word cannot move to the output
  assign hold = result_rdy & out_valid;

  //////////////////////////////////////////////////////////////////////
  // output register
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
    end else if (out_load) begin
      out_valid <= result_rdy;
    end
  end

  always_ff @(posedge clk) begin
    if (out_load) begin
      out_data <= word_d;
      out_abs  <= abs_word;
    end
  end

endmodule

//--- logic/cabs_core.sv
//////////////////////////////////////////////////////////////////////
// Shared magnitude pipeline, one channel per step.
// Stage one folds and sorts the parts, stage two forms the
// alpha-max-plus-beta-min sum. Latency is two steps.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module cabs_core import anchor_pkg::*, cabs_math_pkg::*; #(
  parameter int NUM_CHANNELS  = NUM_CHANNELS_DEF,
  parameter int CHANNEL_WIDTH = CHANNEL_WIDTH_DEF,

  localparam int WORD_WIDTH = word_width(CHANNEL_WIDTH)
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         step,
  input  logic signed [WORD_WIDTH-1:0] re,
  input  logic signed [WORD_WIDTH-1:0] im,
  output logic [WORD_WIDTH-1:0]        mag
);

  math_word_t abs_re;
  math_word_t abs_im;
  math_word_t est;

  logic [WORD_WIDTH-1:0] hi_q;
  logic [WORD_WIDTH-1:0] lo_q;

  //////////////////////////////////////////////////////////////////////
  // stage one, fold and sort
  //////////////////////////////////////////////////////////////////////

  // sign-extend into the math word before folding
  assign abs_re = fold_abs(MATH_WIDTH'(re));
  assign abs_im = fold_abs(MATH_WIDTH'(im));

  always_ff @(posedge clk) begin
    if (rst) begin
      hi_q <= '0;
      lo_q <= '0;
    end else if (step) begin
      if (abs_re[WORD_WIDTH-1:0] >= abs_im[WORD_WIDTH-1:0]) begin
        hi_q <= abs_re[WORD_WIDTH-1:0];
        lo_q <= abs_im[WORD_WIDTH-1:0];
      end else begin
        hi_q <= abs_im[WORD_WIDTH-1:0];
        lo_q <= abs_re[WORD_WIDTH-1:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage two, max + min/4 + min/8
  //////////////////////////////////////////////////////////////////////

  assign est = amax_bmin(MATH_WIDTH'(hi_q), MATH_WIDTH'(lo_q));

  always_ff @(posedge clk) begin
    if (rst) begin
      mag <= '0;
    end else if (step) begin
      mag <= est[WORD_WIDTH-1:0];
    end
  end

endmodule

//--- logic/anchor_ingress.sv
//////////////////////////////////////////////////////////////////////
// Input side of the magnitude subsystem.
// Walks the presented word one channel per step, splits the chosen
// channel into re and im, and accepts the word on its last channel.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module anchor_ingress import anchor_pkg::*; #(
  parameter int NUM_CHANNELS  = NUM_CHANNELS_DEF,
  parameter int CHANNEL_WIDTH = CHANNEL_WIDTH_DEF,

  localparam int WORD_WIDTH  = word_width(CHANNEL_WIDTH),
  localparam int DATA_WIDTH  = CHANNEL_WIDTH * NUM_CHANNELS,
  localparam int COUNT_WIDTH = count_width(NUM_CHANNELS)
) (
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         in_valid,
  input  logic [DATA_WIDTH-1:0]        in_data,
  input  logic                         hold,
  output logic                         in_ready,
  output logic                         step,
  output logic signed [WORD_WIDTH-1:0] re,
  output logic signed [WORD_WIDTH-1:0] im,
  output logic [COUNT_WIDTH-1:0]       chan,
  output logic                         last
);

  localparam logic [COUNT_WIDTH-1:0] LAST_IDX = COUNT_WIDTH'(NUM_CHANNELS - 1);

  logic [CHANNEL_WIDTH-1:0] lanes [NUM_CHANNELS];
  logic [CHANNEL_WIDTH-1:0] sel;
  logic [COUNT_WIDTH-1:0]   cnt;

  // unpack the bus word into channels
  for (genvar n = 0; n < NUM_CHANNELS; n++) begin : g_unpack
    assign lanes[n] = in_data[n*CHANNEL_WIDTH +: CHANNEL_WIDTH];
  end

  //////////////////////////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////////////////////////

  assign step = in_valid & ~hold;
  assign last = (cnt == LAST_IDX);

  // word is taken when its final channel goes in
  assign in_ready = last & ~hold;

  // channel counter, wraps on the accepting step
  always_ff @(posedge clk) begin
    if (rst) begin
      cnt <= '0;
    end else if (step) begin
      if (last) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // channel select
  //////////////////////////////////////////////////////////////////////

  assign sel  = lanes[cnt];
  assign chan = cnt;

  // re low half, im high half
  assign re = sel[WORD_WIDTH-1:0];
  assign im = sel[CHANNEL_WIDTH-1:WORD_WIDTH];

endmodule

//--- logic/delay_line.sv
//////////////////////////////////////////////////////////////////////
// Step-gated shift register for any payload type.
// Keeps side data aligned with the magnitude pipeline. The output
// shows din from DEPTH steps earlier.
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module delay_line #(
  parameter int  DEPTH     = 2,
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     step,
  input  payload_t din,
  output payload_t dout
);

  payload_t stages [DEPTH];

  // shift only when the pipeline advances
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < DEPTH; i++) begin
        stages[i] <= '0;
      end
    end else if (step) begin
      stages[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stages[i] <= stages[i-1];
      end
    end
  end

  assign dout = stages[DEPTH-1];

endmodule

//--- logic/cabs_math_pkg.sv
//////////////////////////////////////////////////////////////////////
// Arithmetic for the alpha-max-plus-beta-min magnitude estimate.
// The helpers work on a fixed 32-bit math word. Callers sign-extend
// their half-word into it and keep the low bits of the result.
//////////////////////////////////////////////////////////////////////

package cabs_math_pkg;

  // cycles through the magnitude pipeline, fold/sort then sum
  localparam int CABS_DELAY = 2;

  // widest half-word the helpers accept
  localparam int MATH_WIDTH = 32;

  typedef logic [MATH_WIDTH-1:0] math_word_t;

  // absolute value of a sign-extended part, as unsigned
  // the most negative input folds to its exact magnitude
  function automatic math_word_t fold_abs(input logic signed [MATH_WIDTH-1:0] x);
    math_word_t r;
    if (x[MATH_WIDTH-1]) begin
      r = math_word_t'(-x);
    end else begin
      r = math_word_t'(x);
    end
    return r;
  endfunction

  // max + min/4 + min/8, truncating shifts
  // stays below 1.375 * max so no carry out of the half-word
  function automatic math_word_t amax_bmin(input math_word_t hi, input math_word_t lo);
    math_word_t r;
    r = hi + (lo >> 2) + (lo >> 3);
    return r;
  endfunction

endpackage

//--- logic/anchor_pkg.sv
//////////////////////////////////////////////////////////////////////
// Channel geometry for the anchor receiver datapath.
// Holds the default channel count and width and the helpers that
// derive lane and index widths. Import it into the module header.
//////////////////////////////////////////////////////////////////////

package anchor_pkg;

  // one antenna per channel
  localparam int NUM_CHANNELS_DEF = 4;

  // complex sample, re in the low half and im in the high half
  localparam int CHANNEL_WIDTH_DEF = 32;

  // width of one real or imaginary part
  function automatic int word_width(input int channel_width);
    return channel_width / 2;
  endfunction

  // index width for a channel count, never below one bit
  function automatic int count_width(input int num_channels);
    int w;
    if (num_channels > 1) begin
      w = $clog2(num_channels);
    end else begin
      w = 1;
    end
    return w;
  endfunction

  // channel index at the default geometry
  typedef logic [count_width(NUM_CHANNELS_DEF)-1:0] chan_idx_t;

endpackage
